//--- bench/tb_sensor_bridge.sv
`default_nettype none

module tb_sensor_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    import sensor_bridge_pkg::*;

    localparam int reset_cycles = 16;
    localparam int hold_phase   = 300;                 // spans the 256 edge hold
    localparam int main_cycles  = 2000;
    localparam int test_cycles  = hold_phase + main_cycles;

    // --------------------
    // dut signals
    // --------------------

    logic                python_clk = 1'b0;
    logic                mipi_reset_n;
    rx_raw_t             python_data_raw;
    bitslip_t            bitslip_req;
    logic                dphy_init_done;
    logic                dphy_cl_txclkactivehs;
    logic [hs_lanes-1:0] dphy_dl_txreadyhs;
    logic                python_io_reset;
    bitslip_t            python_bitslip;
    rx_frame_t           python_frame;
    logic                dphy_cl_txrequesths;
    logic [hs_lanes-1:0] dphy_dl_txrequesths;
    hs_byte_t            dphy_dl0_txdatahs;
    hs_byte_t            dphy_dl1_txdatahs;
    logic                sensor_pwr_enable;
    logic [1:0]          led;
    logic [7:0]          pmod;

    // --------------------
    // reference model state
    // --------------------

    int unsigned             m_hold;
    logic                    m_io_reset;
    bitslip_t                m_bitslip;
    rx_frame_t               m_frame;
    logic                    m_meta;
    logic                    m_sync;
    logic                    m_cl_req;
    logic [hs_lanes-1:0]     m_dl_req;
    logic [7:0]              m_warm;           // warm-up counter
    hs_byte_t                m_byte0;
    hs_byte_t                m_byte1;
    logic                    m_pwr;
    logic [act_cnt_bits-1:0] m_act;

    int          frame_errs  = 0;
    int          slip_errs   = 0;
    int          byte_errs   = 0;
    int          bit_errs    = 0;
    int          timing_errs = 0;
    int          edge_cnt    = 0;              // rising edges since release
    int          init_edge   = -1;
    int          cl_edge     = -1;
    int          dl_edge     = -1;
    int          io_edge     = -1;
    logic [31:0] rng         = 32'd21597;

    sensor_bridge_top sensor_bridge_top_i (.*);

    always #2 python_clk = ~python_clk;        // 4 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // raw bit k belongs to channel k mod 5, bit k div 5
    function automatic rx_frame_t transpose(input rx_raw_t raw);
        rx_frame_t f;
        f = '0;
        for (int k = 0; k < rx_raw_bits; k++) begin
            f[k % rx_channels][k / rx_channels] = raw[k];
        end
        return f;
    endfunction

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_frame(input rx_frame_t got, input rx_frame_t exp);
        for (int i = 0; i < rx_channels; i++) begin
            if (got[i] !== exp[i]) begin
                frame_errs++;
                $display("FAILED at %0t: python_frame channel %0d got %h expected %h",
                         $time, i, got[i], exp[i]);
            end
        end
    endtask

    task automatic check_bitslip(input bitslip_t got, input bitslip_t exp);
        if (got !== exp) begin
            slip_errs++;
            $display("FAILED at %0t: python_bitslip got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic check_hs_byte(input hs_byte_t got, input hs_byte_t exp, input string what);
        if (got !== exp) begin
            byte_errs++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            bit_errs++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // --------------------
    // model
    // --------------------

    task automatic model_reset();
        m_hold     = io_hold_cycles - 1;
        m_io_reset = 1'b1;
        m_bitslip  = '0;
        m_frame    = '0;
        m_meta     = 1'b0;
        m_sync     = 1'b0;
        m_cl_req   = 1'b0;
        m_dl_req   = '0;
        m_warm     = '0;
        m_byte0    = '0;
        m_byte1    = '0;
        m_pwr      = 1'b0;
        m_act      = '0;
    endtask

    // one rising edge; each field is updated before the fields it feeds
    task automatic model_clock();
        m_bitslip  = m_io_reset ? '0 : bitslip_req;
        m_io_reset = (m_hold != 0);
        m_hold     = (m_hold != 0) ? m_hold - 1 : 0;
        m_frame    = transpose(python_data_raw);
        if (!m_sync) begin
            m_cl_req = 1'b0;
            m_dl_req = '0;
            m_warm   = '0;
            m_byte0  = '0;
            m_byte1  = '0;
        end
        else begin
            m_cl_req = 1'b1;
            m_dl_req = {hs_lanes{m_warm[hs_warmup_bit]}};
            m_warm   = dphy_cl_txclkactivehs ? m_warm + 8'd1 : 8'd0;
            m_byte0  = dphy_dl_txreadyhs[0] ? m_byte0 + 8'd1 : m_byte0;
            m_byte1  = dphy_dl_txreadyhs[1] ? m_byte1 - 8'd1 : m_byte1;
        end
        m_sync = m_meta;
        m_meta = dphy_init_done;
        m_pwr  = 1'b1;
        m_act  = m_act + 1'b1;
        edge_cnt++;
    endtask

    task automatic check_outputs();
        check_bit(python_io_reset, m_io_reset, "python_io_reset");
        check_bitslip(python_bitslip, m_bitslip);
        check_frame(python_frame, m_frame);
        check_bit(dphy_cl_txrequesths, m_cl_req, "dphy_cl_txrequesths");
        check_bit(dphy_dl_txrequesths[0], m_dl_req[0], "dphy_dl_txrequesths[0]");
        check_bit(dphy_dl_txrequesths[1], m_dl_req[1], "dphy_dl_txrequesths[1]");
        check_hs_byte(dphy_dl0_txdatahs, m_byte0, "dphy_dl0_txdatahs");
        check_hs_byte(dphy_dl1_txdatahs, m_byte1, "dphy_dl1_txdatahs");
        check_bit(sensor_pwr_enable, m_pwr, "sensor_pwr_enable");
        check_bit(led[0], m_pwr, "led[0]");
        check_bit(led[1], m_act[led_blink_bit], "led[1]");
        check_hs_byte(pmod, m_act[15:8], "pmod");
        if (python_io_reset === 1'b0 && io_edge < 0) begin
            io_edge = edge_cnt;
        end
        if (dphy_cl_txrequesths === 1'b1 && cl_edge < 0) begin
            cl_edge = edge_cnt;
        end
        if (dphy_dl_txrequesths[0] === 1'b1 && dl_edge < 0) begin
            dl_edge = edge_cnt;
        end
    endtask

    // called on a falling edge: drive, step the model, check on the next fall
    task automatic run_cycle(input logic init_done, input logic clk_active);
        rng                   = xorshift(rng);
        python_data_raw       = rng[rx_raw_bits-1:0];
        rng                   = xorshift(rng);
        bitslip_req           = rng[rx_channels-1:0];
        dphy_dl_txreadyhs     = rng[9:8];
        dphy_init_done        = init_done;
        dphy_cl_txclkactivehs = clk_active;
        if (init_done && init_edge < 0) begin
            init_edge = edge_cnt;
        end
        model_clock();
        @(negedge python_clk);
        check_outputs();
    endtask

    // --------------------
    // stimulus
    // --------------------

    initial begin
        int init_cycle;
        int pulse_start;
        int pulse_len;
        mipi_reset_n          = 1'b0;
        python_data_raw       = '0;
        bitslip_req           = '0;
        dphy_init_done        = 1'b0;
        dphy_cl_txclkactivehs = 1'b0;
        dphy_dl_txreadyhs     = '0;
        model_reset();
        repeat (reset_cycles) begin
            @(negedge python_clk);
            check_outputs();
        end
        mipi_reset_n = 1'b1;

        repeat (hold_phase) run_cycle(1'b0, 1'b0);  // hold with random bitslip
        if (io_edge != io_hold_cycles) begin
            timing_errs++;
            $display("python_io_reset fell after %0d edges instead of %0d", io_edge,
                     io_hold_cycles);
        end

        rng         = xorshift(rng);
        init_cycle  = 20 + int'(rng % 256);
        rng         = xorshift(rng);
        pulse_start = 700 + int'(rng % 200);
        rng         = xorshift(rng);
        pulse_len   = 1 + int'(rng % 16);
        for (int c = 0; c < main_cycles; c++) begin
            run_cycle(c >= init_cycle, !(c >= pulse_start && c < pulse_start + pulse_len));
        end

        if (cl_edge - init_edge != 3) begin
            timing_errs++;
            $display("clock request rose %0d edges after init_done, expected 3",
                     cl_edge - init_edge);
        end
        if (dl_edge - cl_edge != 128) begin
            timing_errs++;
            $display("data request rose %0d edges after clock request, expected 128",
                     dl_edge - cl_edge);
        end

        $display("errors: frame %0d, bitslip %0d, byte %0d, bit %0d, timing %0d",
                 frame_errs, slip_errs, byte_errs, bit_errs, timing_errs);
        if (frame_errs + slip_errs + byte_errs + bit_errs + timing_errs == 0) begin
            $display("ALL TESTS PASSED");
        end
        else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // --------------------
    // watchdog
    // --------------------

    initial begin
        #((reset_cycles + test_cycles + 100) * 4);
        $display("watchdog expired before the test sequence finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- common/sensor_bridge_pkg.sv
`default_nettype none

package sensor_bridge_pkg;

    // --------------------
    // python receive path
    // --------------------

    localparam int unsigned rx_channels = 5;                      // four data plus sync
    localparam int unsigned rx_ratio    = 4;                      // bits per channel per clock
    localparam int unsigned rx_raw_bits = rx_channels * rx_ratio; // 20

    // bit j*rx_channels+i of the raw word is bit j of channel i
    typedef logic [rx_raw_bits-1:0] rx_raw_t;

    typedef logic [rx_ratio-1:0] rx_nibble_t;          // one channel sample

    typedef rx_nibble_t [rx_channels-1:0] rx_frame_t;  // index 4 is sync

    typedef logic [rx_channels-1:0] bitslip_t;         // one per channel

    // deserializer start-up hold
    localparam int unsigned io_hold_cycles = 256;
    localparam int unsigned io_hold_bits   = $clog2(io_hold_cycles); // 8 bit counter

    // --------------------
    // d-phy hs pattern
    // --------------------

    localparam int unsigned hs_lanes     = 2;
    localparam int unsigned hs_byte_bits = 8;

    typedef logic [hs_byte_bits-1:0] hs_byte_t;        // one lane's hs byte

    // this bit of the warm-up counter opens the data lanes
    localparam int unsigned hs_warmup_bit = 7;

    // --------------------
    // status
    // --------------------

    localparam int unsigned act_cnt_bits  = 25;        // activity counter width
    localparam int unsigned led_blink_bit = 24;        // slow blink on led[1]
    localparam int unsigned pmod_lsb      = 8;         // pmod shows bits lsb+7..lsb

endpackage

`default_nettype wire

//--- dphy_tx/hs_lane_pattern.sv
`default_nettype none

module hs_lane_pattern (
    input  var logic                                 python_clk,
    input  var logic                                 mipi_reset_n,

    input  var logic                                 dphy_init_done,
    input  var logic                                 dphy_cl_txclkactivehs,
    input  var logic [sensor_bridge_pkg::hs_lanes-1:0] dphy_dl_txreadyhs,

    output var logic                                 dphy_cl_txrequesths,
    output var logic [sensor_bridge_pkg::hs_lanes-1:0] dphy_dl_txrequesths,
    output var sensor_bridge_pkg::hs_byte_t          dphy_dl0_txdatahs,
    output var sensor_bridge_pkg::hs_byte_t          dphy_dl1_txdatahs
);

    import sensor_bridge_pkg::*;

    // --------------------
    // init_done sync
    // --------------------

    logic init_meta;   // first stage
    logic init_sync;   // safe to use

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            init_meta <= 1'b0;
            init_sync <= 1'b0;
        end
        else begin
            init_meta <= dphy_init_done;
            init_sync <= init_meta;
        end
    end

    // --------------------
    // requests and bytes
    // --------------------

    // Once the PHY reports init done the clock lane is requested at once.
    // The data lanes wait until the clock lane has been active for
    // 2**hs_warmup_bit cycles in a row; any gap in txclkactivehs restarts
    // the wait. Each lane's byte advances only when that lane is ready.

    logic [hs_warmup_bit:0] warmup_cnt;

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            dphy_cl_txrequesths <= 1'b0;
            dphy_dl_txrequesths <= '0;
            warmup_cnt          <= '0;
            dphy_dl0_txdatahs   <= '0;
            dphy_dl1_txdatahs   <= '0;
        end
        else if (!init_sync) begin
            dphy_cl_txrequesths <= 1'b0;      // phy not up yet
            dphy_dl_txrequesths <= '0;
            warmup_cnt          <= '0;
            dphy_dl0_txdatahs   <= '0;
            dphy_dl1_txdatahs   <= '0;
        end
        else begin
            dphy_cl_txrequesths <= 1'b1;

            if (dphy_cl_txclkactivehs) begin
                warmup_cnt <= warmup_cnt + 1'b1;
            end
            else begin
                warmup_cnt <= '0;             // clock dropped, start over
            end

            dphy_dl_txrequesths <= {hs_lanes{warmup_cnt[hs_warmup_bit]}};

            if (dphy_dl_txreadyhs[0]) begin
                dphy_dl0_txdatahs <= dphy_dl0_txdatahs + 1'b1;  // rising ramp
            end
            if (dphy_dl_txreadyhs[1]) begin
                dphy_dl1_txdatahs <= dphy_dl1_txdatahs - 1'b1;  // falling ramp
            end
        end
    end

endmodule

`default_nettype wire

//--- python_rx/python_rx_capture.sv
`default_nettype none

module python_rx_capture (
    input  var logic                         python_clk,
    input  var logic                         mipi_reset_n,

    input  var sensor_bridge_pkg::rx_raw_t   python_data_raw,
    input  var sensor_bridge_pkg::bitslip_t  bitslip_req,

    output var logic                         python_io_reset,
    output var sensor_bridge_pkg::bitslip_t  python_bitslip,
    output var sensor_bridge_pkg::rx_frame_t python_frame
);

    import sensor_bridge_pkg::*;

    // --------------------
    // start-up hold
    // --------------------

    // The deserializer stays in reset for io_hold_cycles edges after
    // mipi_reset_n releases, so its clocking can settle first.

    logic [io_hold_bits-1:0] hold_cnt;  // counts down to zero

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            hold_cnt        <= io_hold_bits'(io_hold_cycles - 1);
            python_io_reset <= 1'b1;
        end
        else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            python_io_reset <= (hold_cnt != '0);  // old count, falls on edge 256
        end
    end

    // --------------------
    // bitslip forwarding
    // --------------------

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            python_bitslip <= '0;
        end
        else if (python_io_reset) begin
            python_bitslip <= '0;            // no slips while held
        end
        else begin
            python_bitslip <= bitslip_req;   // one cycle delay
        end
    end

    // --------------------
    // channel reorder
    // --------------------

    // The raw word is interleaved by bit position: the lowest
    // rx_channels bits hold bit 0 of every channel, the next group bit 1,
    // and so on. Pull each channel's bits back together.

    rx_frame_t frame_next;

    always_comb begin
        frame_next = '0;
        for (int i = 0; i < rx_channels; i++) begin
            for (int j = 0; j < rx_ratio; j++) begin
                frame_next[i][j] = python_data_raw[j*rx_channels + i];
            end
        end
    end

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            python_frame <= '0;
        end
        else begin
            python_frame <= frame_next;   // new frame every cycle
        end
    end

endmodule

`default_nettype wire

//--- source/sensor_bridge_top.sv
`default_nettype none

module sensor_bridge_top (
    input  var logic                                   python_clk,
    input  var logic                                   mipi_reset_n,

    // python deserializer side
    input  var sensor_bridge_pkg::rx_raw_t             python_data_raw,
    input  var sensor_bridge_pkg::bitslip_t            bitslip_req,
    output var logic                                   python_io_reset,
    output var sensor_bridge_pkg::bitslip_t            python_bitslip,
    output var sensor_bridge_pkg::rx_frame_t           python_frame,

    // d-phy ppi side
    input  var logic                                   dphy_init_done,
    input  var logic                                   dphy_cl_txclkactivehs,
    input  var logic [sensor_bridge_pkg::hs_lanes-1:0] dphy_dl_txreadyhs,
    output var logic                                   dphy_cl_txrequesths,
    output var logic [sensor_bridge_pkg::hs_lanes-1:0] dphy_dl_txrequesths,
    output var sensor_bridge_pkg::hs_byte_t            dphy_dl0_txdatahs,
    output var sensor_bridge_pkg::hs_byte_t            dphy_dl1_txdatahs,

    // board status
    output var logic                                   sensor_pwr_enable,
    output var logic [1:0]                             led,
    output var logic [7:0]                             pmod
);

    // --------------------
    // receive front end
    // --------------------

    python_rx_capture python_rx_capture_i (
        .python_clk      (python_clk),
        .mipi_reset_n    (mipi_reset_n),
        .python_data_raw (python_data_raw),
        .bitslip_req     (bitslip_req),
        .python_io_reset (python_io_reset),
        .python_bitslip  (python_bitslip),
        .python_frame    (python_frame)
    );

    // --------------------
    // hs test pattern
    // --------------------

    hs_lane_pattern hs_lane_pattern_i (
        .python_clk            (python_clk),
        .mipi_reset_n          (mipi_reset_n),
        .dphy_init_done        (dphy_init_done),
        .dphy_cl_txclkactivehs (dphy_cl_txclkactivehs),
        .dphy_dl_txreadyhs     (dphy_dl_txreadyhs),       // both lanes as one vector
        .dphy_cl_txrequesths   (dphy_cl_txrequesths),
        .dphy_dl_txrequesths   (dphy_dl_txrequesths),
        .dphy_dl0_txdatahs     (dphy_dl0_txdatahs),
        .dphy_dl1_txdatahs     (dphy_dl1_txdatahs)
    );

    // --------------------
    // status
    // --------------------

    status_indicator status_indicator_i (
        .python_clk        (python_clk),
        .mipi_reset_n      (mipi_reset_n),
        .sensor_pwr_enable (sensor_pwr_enable),
        .led               (led),
        .pmod              (pmod)
    );

endmodule

`default_nettype wire

//--- source/status_indicator.sv
`default_nettype none

module status_indicator (
    input  var logic       python_clk,
    input  var logic       mipi_reset_n,

    output var logic       sensor_pwr_enable,
    output var logic [1:0] led,
    output var logic [7:0] pmod
);

    import sensor_bridge_pkg::*;

    // --------------------
    // power enable
    // --------------------

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            sensor_pwr_enable <= 1'b0;
        end
        else begin
            sensor_pwr_enable <= 1'b1;   // set on first edge after release
        end
    end

    // --------------------
    // activity counter
    // --------------------

    logic [act_cnt_bits-1:0] act_cnt;  // free running

    always_ff @(posedge python_clk or negedge mipi_reset_n) begin
        if (!mipi_reset_n) begin
            act_cnt <= '0;
        end
        else begin
            act_cnt <= act_cnt + 1'b1;
        end
    end

    assign led[0] = sensor_pwr_enable;
    assign led[1] = act_cnt[led_blink_bit];   // visible blink
    assign pmod   = act_cnt[pmod_lsb +: 8];   // middle byte to scope header

endmodule

`default_nettype wire

//--- src.f
common/sensor_bridge_pkg.sv
python_rx/python_rx_capture.sv
dphy_tx/hs_lane_pattern.sv
source/status_indicator.sv
source/sensor_bridge_top.sv
bench/tb_sensor_bridge.sv
